// ==== design/vita_tx_pkg.sv ====
package vita_tx_pkg;

   // Header view of a stream word
   typedef struct packed {
      logic        has_time;
      logic        sob;
      logic        eob;
      logic [3:0]  seqnum;
      logic [8:0]  reserved;
      logic [15:0] sample_count;
   } vita_hdr_t;

   typedef union packed {
      vita_hdr_t   hdr;
      logic [31:0] raw;   // Time words and samples
   } vita_word_u;

   typedef struct packed {
      logic        seqnum_err;
      logic        send_at;
      logic        sob;
      logic        eob;
      logic        eop;
      logic [63:0] send_time;
      logic [31:0] sample;
   } sample_entry_t;

   typedef enum logic [3:0] {
      ERR_NONE     = 4'd0,
      ERR_UNDERRUN = 4'd2,
      ERR_SEQ      = 4'd4,
      ERR_TIME     = 4'd8
   } error_code_t;

   localparam logic [7:0] REG_CTRL    = 8'h00;   // Write clears
   localparam logic [7:0] REG_TIME_HI = 8'h04;
   localparam logic [7:0] REG_TIME_LO = 8'h08;   // Write loads time
   localparam logic [7:0] REG_STATUS  = 8'h0C;
   localparam logic [7:0] REG_NOW_HI  = 8'h10;
   localparam logic [7:0] REG_NOW_LO  = 8'h14;

   typedef struct packed {
      logic [7:0]  awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic        wvalid;
      logic        bready;
      logic [7:0]  araddr;
      logic        arvalid;
      logic        rready;
   } axil_req_t;

   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

endpackage

// ==== design/time_compare.sv ====
`timescale 1ns/100ps

module time_compare
(
   input  logic [63:0] time_now_i,
   input  logic [63:0] trigger_time_i,
   output logic        now_o,
   output logic        early_o,
   output logic        late_o
);

   assign now_o   = (time_now_i == trigger_time_i);
   assign early_o = (trigger_time_i > time_now_i);   // Not yet due
   assign late_o  = (trigger_time_i < time_now_i);

endmodule

// ==== design/vita_tx_regs.sv ====
`timescale 1ns/100ps

module vita_tx_regs
   import vita_tx_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,
   input  axil_req_t   axil_req_i,
   output axil_rsp_t   axil_rsp_o,
   input  logic        status_error_i,
   input  logic        status_run_i,
   input  error_code_t status_code_i,
   output logic [63:0] vita_time_o,
   output logic        clear_o
);

   logic        aw_got;
   logic        w_got;
   logic        bvalid;
   logic        rvalid;
   logic [7:0]  awaddr_q;
   logic [31:0] wdata_q;
   logic [31:0] time_hi_q;
   logic [31:0] rdata_q;
   logic [31:0] rd_mux;
   logic        aw_hs;
   logic        w_hs;
   logic        ar_hs;
   logic        do_write;
   logic [7:0]  wr_addr;
   logic [31:0] wr_data;

   assign aw_hs    = axil_req_i.awvalid & ~aw_got & ~bvalid;
   assign w_hs     = axil_req_i.wvalid & ~w_got & ~bvalid;
   assign ar_hs    = axil_req_i.arvalid & ~rvalid;
   assign do_write = (aw_got | aw_hs) & (w_got | w_hs);
   assign wr_addr  = aw_got ? awaddr_q : axil_req_i.awaddr;
   assign wr_data  = w_got ? wdata_q : axil_req_i.wdata;

   always_comb
   begin
      case (axil_req_i.araddr)
         REG_TIME_HI: rd_mux = time_hi_q;
         REG_STATUS:  rd_mux = {26'd0, status_run_i, status_error_i, status_code_i};
         REG_NOW_HI:  rd_mux = vita_time_o[63:32];
         REG_NOW_LO:  rd_mux = vita_time_o[31:0];
         default:     rd_mux = 32'd0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         aw_got      <= 1'b0;
         w_got       <= 1'b0;
         bvalid      <= 1'b0;
         rvalid      <= 1'b0;
         clear_o     <= 1'b0;
         vita_time_o <= 64'd0;
      end
      else
      begin
         clear_o     <= 1'b0;
         vita_time_o <= vita_time_o + 64'd1;
         if (do_write)
         begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b1;
            if (wr_addr == REG_CTRL)
               clear_o <= 1'b1;
            if (wr_addr == REG_TIME_LO)
               vita_time_o <= {time_hi_q, wr_data};   // Counts on from here
         end
         else
         begin
            if (aw_hs)
               aw_got <= 1'b1;
            if (w_hs)
               w_got <= 1'b1;
         end
         if (bvalid && axil_req_i.bready)
            bvalid <= 1'b0;
         if (ar_hs)
            rvalid <= 1'b1;
         else if (axil_req_i.rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_hs)
         awaddr_q <= axil_req_i.awaddr;
      if (w_hs)
         wdata_q <= axil_req_i.wdata;
      if (do_write && wr_addr == REG_TIME_HI)
         time_hi_q <= wr_data;   // Staged until TIME_LO
      if (ar_hs)
         rdata_q <= rd_mux;
   end

   always_comb
   begin
      axil_rsp_o         = '0;   // Responses always OKAY
      axil_rsp_o.awready = ~aw_got & ~bvalid;
      axil_rsp_o.wready  = ~w_got & ~bvalid;
      axil_rsp_o.bvalid  = bvalid;
      axil_rsp_o.arready = ~rvalid;
      axil_rsp_o.rvalid  = rvalid;
      axil_rsp_o.rdata   = rdata_q;
   end

   // Write response only after both channels taken
   a_bvalid_after_write: assert property (@(posedge clk) disable iff (!arst_n_i)
      $rose(bvalid) |-> $past(do_write));

endmodule

// ==== design/vita_tx_deframer.sv ====
`timescale 1ns/100ps

module vita_tx_deframer
   import vita_tx_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  logic          clear_i,
   input  vita_word_u    in_data_i,
   input  logic          in_valid_i,
   output logic          in_ready_o,
   input  logic          fifo_full_i,
   output logic          push_o,
   output sample_entry_t entry_o
);

   typedef enum logic [1:0] {
      S_HEADER,
      S_TIME_HI,
      S_TIME_LO,
      S_SAMPLES
   } dfr_state_t;

   dfr_state_t  state;
   logic        xfer;
   logic [3:0]  exp_seq;
   logic [15:0] count;
   logic        seq_err_q;
   logic        send_at_q;
   logic        sob_q;
   logic        eob_q;
   logic [63:0] send_time_q;

   assign in_ready_o = ~fifo_full_i;
   assign xfer       = in_valid_i & in_ready_o;
   assign push_o     = xfer & (state == S_SAMPLES);

   always_comb
   begin
      entry_o.seqnum_err = seq_err_q;
      entry_o.send_at    = send_at_q;
      entry_o.sob        = sob_q;
      entry_o.eob        = eob_q;
      entry_o.eop        = (count == 16'd1);   // Last of the packet
      entry_o.send_time  = send_time_q;
      entry_o.sample     = in_data_i.raw;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state     <= S_HEADER;
         exp_seq   <= 4'd0;
         count     <= 16'd0;
         seq_err_q <= 1'b0;
         send_at_q <= 1'b0;
         sob_q     <= 1'b0;
         eob_q     <= 1'b0;
      end
      else if (clear_i)
      begin
         state   <= S_HEADER;
         exp_seq <= 4'd0;
      end
      else if (xfer)
      begin
         case (state)
            S_HEADER:
            begin
               // Flag a gap, then resync on what arrived
               seq_err_q <= (in_data_i.hdr.seqnum != exp_seq);
               exp_seq   <= in_data_i.hdr.seqnum + 4'd1;
               send_at_q <= in_data_i.hdr.has_time;
               sob_q     <= in_data_i.hdr.sob;
               eob_q     <= in_data_i.hdr.eob;
               count     <= in_data_i.hdr.sample_count;
               state     <= in_data_i.hdr.has_time ? S_TIME_HI : S_SAMPLES;
            end
            S_TIME_HI: state <= S_TIME_LO;
            S_TIME_LO: state <= S_SAMPLES;
            S_SAMPLES:
            begin
               sob_q <= 1'b0;   // Only on first sample
               count <= count - 16'd1;
               if (count == 16'd1)
                  state <= S_HEADER;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (xfer && state == S_TIME_HI)
         send_time_q[63:32] <= in_data_i.raw;
      if (xfer && state == S_TIME_LO)
         send_time_q[31:0] <= in_data_i.raw;
   end

   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
      push_o |-> !fifo_full_i);

endmodule

// ==== design/sample_fifo.sv ====
`timescale 1ns/100ps

module sample_fifo
   import vita_tx_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
)
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  logic          push_i,
   input  sample_entry_t entry_i,
   input  logic          pop_i,
   output sample_entry_t entry_o,
   output logic          full_o,
   output logic          empty_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   sample_entry_t mem [FIFO_DEPTH];
   logic [AW:0]   wr_ptr;   // Extra bit tells full from empty
   logic [AW:0]   rd_ptr;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});
   assign entry_o = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_i)
         mem[wr_ptr[AW-1:0]] <= entry_i;
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
      pop_i |-> !empty_o);
   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
      push_i |-> !full_o);

endmodule

// ==== design/vita_tx_control.sv ====
`timescale 1ns/100ps

module vita_tx_control
   import vita_tx_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  logic          clear_i,
   input  logic [63:0]   vita_time_i,
   input  sample_entry_t head_i,
   input  logic          head_rdy_i,
   output logic          pop_o,
   input  logic          strobe_i,
   output logic [31:0]   sample_o,
   output logic          run_o,
   output logic          error_o,
   output error_code_t   error_code_o
);

   typedef enum logic [2:0] {
      S_IDLE       = 3'd0,
      S_RUN        = 3'd1,
      S_CONT_BURST = 3'd2,
      S_UNDERRUN   = 3'd3,
      S_TIME_ERROR = 3'd4,
      S_SEQ_ERROR  = 3'd5,
      S_ERROR_DONE = 3'd7
   } ctl_state_t;

   ctl_state_t state;
   logic       now;
   logic       early;
   logic       late;

   time_compare i_time_compare
   (
      .time_now_i     (vita_time_i),
      .trigger_time_i (head_i.send_time),
      .now_o          (now),
      .early_o        (early),
      .late_o         (late)
   );

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state        <= S_IDLE;
         error_code_o <= ERR_NONE;
      end
      else if (clear_i)
      begin
         state        <= S_IDLE;
         error_code_o <= ERR_NONE;
      end
      else
      begin
         case (state)
            S_IDLE:
               if (head_rdy_i)
               begin
                  if (head_i.seqnum_err)
                     state <= S_SEQ_ERROR;
                  else if (!head_i.send_at || now)
                     state <= S_RUN;
                  else if (late && !early)
                     state <= S_TIME_ERROR;   // Missed its slot
               end
            S_RUN:
               if (strobe_i)
               begin
                  if (!head_rdy_i)
                     state <= S_UNDERRUN;
                  else if (head_i.eop)
                     state <= head_i.eob ? S_IDLE : S_CONT_BURST;
               end
            S_CONT_BURST:
               if (strobe_i)
                  state <= S_ERROR_DONE;   // Next packet too slow
               else if (head_rdy_i)
                  state <= head_i.seqnum_err ? S_SEQ_ERROR : S_RUN;
            S_UNDERRUN:
            begin
               error_code_o <= ERR_UNDERRUN;
               if (head_rdy_i && head_i.eop)
                  state <= S_ERROR_DONE;
            end
            S_TIME_ERROR:
            begin
               error_code_o <= ERR_TIME;
               state        <= S_ERROR_DONE;
            end
            S_SEQ_ERROR:
            begin
               error_code_o <= ERR_SEQ;
               state        <= S_ERROR_DONE;
            end
            default: ;   // Stuck until clear
         endcase
      end
   end

   // Underrun flushes the rest of the packet
   assign pop_o    = head_rdy_i & ((state == S_UNDERRUN) | (strobe_i & (state == S_RUN)));
   assign sample_o = head_i.sample;
   assign run_o    = (state == S_RUN) | (state == S_CONT_BURST);
   assign error_o  = (state == S_ERROR_DONE);

   a_pop_has_data: assert property (@(posedge clk) disable iff (!arst_n_i)
      pop_o |-> head_rdy_i);

endmodule

// ==== design/vita_tx_top.sv ====
`timescale 1ns/100ps

module vita_tx_top
   import vita_tx_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
)
(
   input  logic        clk,
   input  logic        arst_n_i,
   input  axil_req_t   axil_req_i,
   output axil_rsp_t   axil_rsp_o,
   input  vita_word_u  in_data_i,
   input  logic        in_valid_i,
   output logic        in_ready_o,
   input  logic        strobe_i,
   output logic [31:0] sample_o,
   output logic        run_o,
   output logic        error_o,
   output error_code_t error_code_o
);

   logic [63:0]   vita_time;
   logic          clear;
   logic          fifo_push;
   sample_entry_t fifo_in;
   logic          fifo_pop;
   sample_entry_t fifo_head;
   logic          fifo_full;
   logic          fifo_empty;

   vita_tx_regs i_vita_tx_regs
   (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .axil_req_i     (axil_req_i),
      .axil_rsp_o     (axil_rsp_o),
      .status_error_i (error_o),
      .status_run_i   (run_o),
      .status_code_i  (error_code_o),
      .vita_time_o    (vita_time),
      .clear_o        (clear)
   );

   vita_tx_deframer i_vita_tx_deframer
   (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .clear_i     (clear),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .fifo_full_i (fifo_full),
      .push_o      (fifo_push),
      .entry_o     (fifo_in)
   );

   sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_sample_fifo
   (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .push_i   (fifo_push),
      .entry_i  (fifo_in),
      .pop_i    (fifo_pop),
      .entry_o  (fifo_head),
      .full_o   (fifo_full),
      .empty_o  (fifo_empty)
   );

   vita_tx_control i_vita_tx_control
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .clear_i      (clear),
      .vita_time_i  (vita_time),
      .head_i       (fifo_head),
      .head_rdy_i   (~fifo_empty),
      .pop_o        (fifo_pop),
      .strobe_i     (strobe_i),
      .sample_o     (sample_o),
      .run_o        (run_o),
      .error_o      (error_o),
      .error_code_o (error_code_o)
   );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock
#(
   parameter int PERIOD_NS = 100
)
(
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule

// ==== tests/vita_tx_tb.sv ====
`timescale 1ns/100ps

module vita_tx_tb;
   import vita_tx_pkg::*;

   localparam int CLK_PERIOD    = 100;
   localparam int DRIVE_DELAY   = 10;
   localparam int STROBE_DIV    = 4;
   localparam int TOTAL_SAMPLES = 40;   // All packets together
   localparam int WATCHDOG_CYC  = TOTAL_SAMPLES * STROBE_DIV + 1000;
   localparam int WAIT_CYC      = 300;

   logic        clk;
   logic        arst_n;
   axil_req_t   axil_req;
   axil_rsp_t   axil_rsp;
   vita_word_u  in_data;
   logic        in_valid;
   logic        in_ready;
   logic        strobe;
   logic [31:0] sample;
   logic        run;
   logic        error;
   error_code_t error_code;

   logic [31:0] lfsr;
   logic [31:0] exp_q [$];
   int          assert_errors;
   int          check_errors;
   logic        strobe_en;
   int          strobe_cnt;
   logic [63:0] tb_time;      // Mirror of the VITA time counter
   logic [31:0] tb_time_hi;
   logic [63:0] send_at_time;
   logic        timed_armed;
   logic        late_armed;
   logic        allow_error;
   logic        expect_error;
   error_code_t expect_code;

   tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_tb_clock
   (
      .clk_o (clk)
   );

   vita_tx_top #(.FIFO_DEPTH(16)) i_vita_tx_top
   (
      .clk          (clk),
      .arst_n_i     (arst_n),
      .axil_req_i   (axil_req),
      .axil_rsp_o   (axil_rsp),
      .in_data_i    (in_data),
      .in_valid_i   (in_valid),
      .in_ready_o   (in_ready),
      .strobe_i     (strobe),
      .sample_o     (sample),
      .run_o        (run),
      .error_o      (error),
      .error_code_o (error_code)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      for (int i = 0; i < 32; i++)
         w = {w[30:0], lfsr_bit()};
      return w;
   endfunction

   function automatic logic write_taken(input logic [7:0] addr);
      return axil_req.awvalid && axil_req.wvalid && axil_rsp.awready && axil_rsp.wready
             && axil_req.awaddr == addr;
   endfunction

   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         tb_time <= 64'd0;
      else if (write_taken(REG_TIME_LO))
         tb_time <= {tb_time_hi, axil_req.wdata};
      else
         tb_time <= tb_time + 64'd1;
   end

   always @(posedge clk)
   begin
      if (write_taken(REG_TIME_HI))
         tb_time_hi <= axil_req.wdata;
   end

   initial
   begin
      strobe     = 1'b0;
      strobe_cnt = 0;
      forever
      begin
         @(posedge clk);
         #DRIVE_DELAY;
         strobe_cnt = (strobe_cnt + 1) % STROBE_DIV;
         strobe     = strobe_en && (strobe_cnt == 0);
      end
   end

   // Scoreboard checks one sample per strobe while running
   always @(posedge clk)
   begin
      if (arst_n && strobe && run && exp_q.size() > 0)
      begin
         a_sample: assert (sample == exp_q[0])
         else
         begin
            assert_errors++;
            $display("Fail %0t: sample_o %h, expected %h", $time, sample, exp_q[0]);
         end
         void'(exp_q.pop_front());
      end
   end

   a_reset_state: assert property (@(posedge clk)
      $rose(arst_n) |-> in_ready && !run && !error && error_code == ERR_NONE
                        && !axil_rsp.bvalid && !axil_rsp.rvalid)
   else
   begin
      assert_errors++;
      $display("Fail %0t: outputs not idle after reset", $time);
   end

   a_resp_okay: assert property (@(posedge clk) disable iff (!arst_n)
      (!axil_rsp.bvalid || axil_rsp.bresp == 2'b00)
      && (!axil_rsp.rvalid || axil_rsp.rresp == 2'b00))
   else
   begin
      assert_errors++;
      $display("Fail %0t: AXI4-Lite response %0d/%0d is not OKAY", $time, axil_rsp.bresp,
               axil_rsp.rresp);
   end

   a_no_error: assert property (@(posedge clk) disable iff (!arst_n)
      !allow_error |-> !error)
   else
   begin
      assert_errors++;
      $display("Fail %0t: error_o high, code %0d", $time, error_code);
   end

   a_error_held: assert property (@(posedge clk) disable iff (!arst_n)
      expect_error |-> error && error_code == expect_code && !run)
   else
   begin
      assert_errors++;
      $display("Fail %0t: error state lost, code %0d expected %0d", $time, error_code,
               expect_code);
   end

   a_not_before_time: assert property (@(posedge clk) disable iff (!arst_n)
      timed_armed && $rose(run) |-> tb_time > send_at_time)
   else
   begin
      assert_errors++;
      $display("Fail %0t: run_o rose at time %0d before send time %0d", $time, tb_time,
               send_at_time);
   end

   a_late_no_run: assert property (@(posedge clk) disable iff (!arst_n)
      late_armed |-> !run)
   else
   begin
      assert_errors++;
      $display("Fail %0t: run_o high for a late packet", $time);
   end

   task automatic apply_reset();
      arst_n = 1'b0;
      repeat (5) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
   endtask

   // Tasks start and end 10 ns after a rising edge
   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
      axil_req.awaddr  = addr;
      axil_req.awvalid = 1'b1;
      axil_req.wdata   = data;
      axil_req.wvalid  = 1'b1;
      axil_req.bready  = 1'b1;
      do @(posedge clk); while (!(axil_rsp.awready && axil_rsp.wready));
      #DRIVE_DELAY;
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      do @(posedge clk); while (!axil_rsp.bvalid);
      #DRIVE_DELAY;
      axil_req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
      axil_req.araddr  = addr;
      axil_req.arvalid = 1'b1;
      axil_req.rready  = 1'b1;
      do @(posedge clk); while (!axil_rsp.arready);
      #DRIVE_DELAY;
      axil_req.arvalid = 1'b0;
      do @(posedge clk); while (!axil_rsp.rvalid);
      data = axil_rsp.rdata;
      #DRIVE_DELAY;
      axil_req.rready = 1'b0;
   endtask

   task automatic compare_word(input string what, input logic [31:0] got,
                               input logic [31:0] want);
      if (got !== want)
      begin
         check_errors++;
         $display("Fail %0t: %s read %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic check_status(input logic run_exp, input logic err_exp,
                               input error_code_t code_exp);
      logic [31:0] got;
      axil_read(REG_STATUS, got);
      compare_word("STATUS", got, {26'd0, run_exp, err_exp, code_exp});
   endtask

   task automatic send_word(input logic [31:0] w);
      in_data.raw = w;
      in_valid    = 1'b1;
      do @(posedge clk); while (!in_ready);
      #DRIVE_DELAY;
      in_valid = 1'b0;
   endtask

   task automatic send_samples(input int n, input logic score);
      logic [31:0] s;
      for (int i = 0; i < n; i++)
      begin
         s = rand_word();
         if (score)
            exp_q.push_back(s);
         send_word(s);
      end
   endtask

   task automatic send_packet(input logic [3:0] seqnum, input logic sob, input logic eob,
                              input logic timed, input logic [63:0] send_time,
                              input int hdr_count, input int n_sent, input logic score);
      vita_word_u hdr;
      hdr                  = '0;
      hdr.hdr.has_time     = timed;
      hdr.hdr.sob          = sob;
      hdr.hdr.eob          = eob;
      hdr.hdr.seqnum       = seqnum;
      hdr.hdr.sample_count = hdr_count[15:0];
      send_word(hdr.raw);
      if (timed)
      begin
         send_word(send_time[63:32]);
         send_word(send_time[31:0]);
      end
      send_samples(n_sent, score);
   endtask

   task automatic wait_output(input logic on_error, input logic level);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_CYC)
      begin
         @(posedge clk);
         seen = on_error ? (error === level) : (run === level);
         n++;
      end
      #DRIVE_DELAY;
      if (!seen)
      begin
         check_errors++;
         $display("Timed out after %0d cycles waiting for %s to become %0b", WAIT_CYC,
                  on_error ? "error_o" : "run_o", level);
      end
   endtask

   task automatic check_played(input string what);
      if (exp_q.size() != 0)
      begin
         check_errors++;
         $display("Fail %0t: %s left %0d samples unplayed", $time, what, exp_q.size());
      end
      exp_q.delete();
   endtask

   initial
   begin
      logic [63:0] stale_time;
      logic [63:0] load_time;
      logic [31:0] rd;
      lfsr          = 32'h8ac9e53e;
      assert_errors = 0;
      check_errors  = 0;
      arst_n        = 1'b0;
      axil_req      = '0;
      in_data       = '0;
      in_valid      = 1'b0;
      strobe_en     = 1'b0;
      timed_armed   = 1'b0;
      late_armed    = 1'b0;
      allow_error   = 1'b0;
      expect_error  = 1'b0;
      expect_code   = ERR_NONE;
      send_at_time  = 64'd0;
      apply_reset();
      strobe_en = 1'b1;

      // Two packets form one burst
      send_packet(4'd0, 1'b1, 1'b0, 1'b0, 64'd0, 6, 6, 1'b1);
      send_packet(4'd1, 1'b0, 1'b1, 1'b0, 64'd0, 5, 5, 1'b1);
      wait_output(1'b0, 1'b1);
      wait_output(1'b0, 1'b0);
      check_played("untimed burst");

      axil_write(REG_TIME_HI, 32'h0000_0002);
      axil_write(REG_TIME_LO, 32'h8000_0000);
      axil_read(REG_NOW_HI, rd);
      compare_word("NOW_HI", rd, 32'h0000_0002);
      send_at_time = tb_time + 64'd40;
      timed_armed  = 1'b1;
      send_packet(4'd2, 1'b1, 1'b1, 1'b1, send_at_time, 5, 5, 1'b1);
      wait_output(1'b0, 1'b1);
      wait_output(1'b0, 1'b0);
      timed_armed = 1'b0;
      check_played("timed packet");

      late_armed  = 1'b1;
      allow_error = 1'b1;
      stale_time  = tb_time - 64'd100;
      send_packet(4'd3, 1'b1, 1'b1, 1'b1, stale_time, 4, 4, 1'b1);
      wait_output(1'b1, 1'b1);
      expect_code  = ERR_TIME;
      expect_error = 1'b1;
      check_status(1'b0, 1'b1, ERR_TIME);
      repeat (20) @(posedge clk);
      #DRIVE_DELAY;
      check_status(1'b0, 1'b1, ERR_TIME);
      // Pull the time back so the queued late packet falls due after the clear
      expect_error = 1'b0;
      load_time    = stale_time - 64'd40;
      axil_write(REG_TIME_HI, load_time[63:32]);
      axil_write(REG_TIME_LO, load_time[31:0]);
      send_at_time = stale_time;
      timed_armed  = 1'b1;
      late_armed   = 1'b0;
      axil_write(REG_CTRL, 32'd0);
      check_status(1'b0, 1'b0, ERR_NONE);
      allow_error = 1'b0;
      wait_output(1'b0, 1'b1);
      wait_output(1'b0, 1'b0);
      timed_armed = 1'b0;
      check_played("late packet after clear");

      // Header promises 8 samples but only 3 arrive before the underrun
      allow_error = 1'b1;
      send_packet(4'd0, 1'b1, 1'b1, 1'b0, 64'd0, 8, 3, 1'b1);
      wait_output(1'b0, 1'b1);
      wait_output(1'b0, 1'b0);
      send_samples(5, 1'b0);
      wait_output(1'b1, 1'b1);
      expect_code  = ERR_UNDERRUN;
      expect_error = 1'b1;
      check_played("underrun packet");
      check_status(1'b0, 1'b1, ERR_UNDERRUN);
      expect_error = 1'b0;
      axil_write(REG_CTRL, 32'd0);
      check_status(1'b0, 1'b0, ERR_NONE);

      send_packet(4'd0, 1'b1, 1'b1, 1'b0, 64'd0, 4, 4, 1'b1);
      send_packet(4'd2, 1'b1, 1'b1, 1'b0, 64'd0, 3, 3, 1'b0);   // Skips seqnum 1
      wait_output(1'b1, 1'b1);
      expect_code  = ERR_SEQ;
      expect_error = 1'b1;
      check_played("packet before the sequence gap");
      check_status(1'b0, 1'b1, ERR_SEQ);
      expect_error = 1'b0;
      // Reset empties the FIFO of the flagged entries that a clear would keep
      apply_reset();
      check_status(1'b0, 1'b0, ERR_NONE);
      allow_error = 1'b0;
      send_packet(4'd0, 1'b1, 1'b1, 1'b0, 64'd0, 5, 5, 1'b1);
      wait_output(1'b0, 1'b1);
      wait_output(1'b0, 1'b0);
      check_played("packet after reset");

      repeat (5) @(posedge clk);
      $display("Errors: %0d assertion, %0d compare", assert_errors, check_errors);
      if (assert_errors == 0 && check_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYC);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== files.f ====
design/vita_tx_pkg.sv
design/time_compare.sv
design/vita_tx_regs.sv
design/vita_tx_deframer.sv
design/sample_fifo.sv
design/vita_tx_control.sv
design/vita_tx_top.sv
tests/tb_clock.sv
tests/vita_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vita_tx_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
